// File: verilog.f
design/router_pkg.sv
design/flit_fifo.sv
design/input_port.sv
design/output_arbiter.sv
design/output_port.sv
design/router_top.sv
testbench/tb_router.sv

// File: testbench/tb_router.sv
`timescale 1ns/1ps
`default_nettype none

module tb_router import router_pkg::*; ();

  localparam int num_pkt = 13;
  localparam int max_flits = 16;
  localparam int max_log = 64;
  localparam int drain_limit = 5000;
  localparam coord_t my_x = 4'd1;
  localparam coord_t my_y = 4'd1;

  logic clk;
  logic rst;
  flit_t flit_in_a [NUM_PORTS];
  port_vec_t rts_in;
  port_vec_t dcts_in;
  port_vec_t dcts_out;
  port_vec_t rts_out;
  flit_t flit_out_n;
  flit_t flit_out_e;
  flit_t flit_out_w;
  flit_t flit_out_s;
  flit_t flit_out_l;
  flit_t flit_out_a [NUM_PORTS];

  int pkt_src [num_pkt];
  coord_t pkt_dx [num_pkt];
  coord_t pkt_dy [num_pkt];
  int pkt_len [num_pkt];
  logic [21:0] pkt_base [num_pkt];
  bit pkt_seen [num_pkt];

  flit_t src_mem [NUM_PORTS][max_flits];
  int src_len [NUM_PORTS];
  int src_pos [NUM_PORTS];
  flit_t log_mem [NUM_PORTS][max_log];
  int log_len [NUM_PORTS];
  logic hold_pend [NUM_PORTS];
  flit_t hold_flit [NUM_PORTS];
  int errors;

  router_top #(
    .fifo_depth(4),
    .local_x(my_x),
    .local_y(my_y)
  ) dut0 (
    .clk(clk),
    .rst(rst),
    .flit_in_n(flit_in_a[PORT_N]),
    .flit_in_e(flit_in_a[PORT_E]),
    .flit_in_w(flit_in_a[PORT_W]),
    .flit_in_s(flit_in_a[PORT_S]),
    .flit_in_l(flit_in_a[PORT_L]),
    .rts_in(rts_in),
    .dcts_in(dcts_in),
    .dcts_out(dcts_out),
    .flit_out_n(flit_out_n),
    .flit_out_e(flit_out_e),
    .flit_out_w(flit_out_w),
    .flit_out_s(flit_out_s),
    .flit_out_l(flit_out_l),
    .rts_out(rts_out)
  );

  assign flit_out_a[PORT_N] = flit_out_n;
  assign flit_out_a[PORT_E] = flit_out_e;
  assign flit_out_a[PORT_W] = flit_out_w;
  assign flit_out_a[PORT_S] = flit_out_s;
  assign flit_out_a[PORT_L] = flit_out_l;

  always #50 clk = ~clk;

  function automatic string port_name(int p);
    case (p)
      PORT_N: return "n";
      PORT_E: return "e";
      PORT_W: return "w";
      PORT_S: return "s";
      default: return "l";
    endcase
  endfunction

  // Dimension order: x first, then y.
  function automatic int xy_route(coord_t dx, coord_t dy);
    if (dx > my_x)
      return PORT_E;
    if (dx < my_x)
      return PORT_W;
    if (dy > my_y)
      return PORT_S;
    if (dy < my_y)
      return PORT_N;
    return PORT_L;
  endfunction

  function automatic flit_t expected_flit(int k, int j);
    flit_type_t kind;
    if (pkt_len[k] == 1)
      kind = FLIT_SINGLE;
    else if (j == 0)
      kind = FLIT_HEAD;
    else if (j == pkt_len[k] - 1)
      kind = FLIT_TAIL;
    else
      kind = FLIT_BODY;
    if (j == 0)
      return {kind, pkt_dx[k], pkt_dy[k], pkt_base[k]};
    return {kind, 8'h00, pkt_base[k] + 22'(j)};  // Body and tail carry base plus index.
  endfunction

  function automatic int find_head(flit_t f);
    for (int k = 0; k < num_pkt; k++) begin
      if (expected_flit(k, 0) == f)
        return k;
    end
    return -1;
  endfunction

  function automatic int logged_total();
    int sum;
    sum = 0;
    for (int o = 0; o < NUM_PORTS; o++)
      sum = sum + log_len[o];
    return sum;
  endfunction

  task automatic set_packet(int k, int src, coord_t dx, coord_t dy, int len,
                            logic [21:0] base);
    pkt_src[k] = src;
    pkt_dx[k] = dx;
    pkt_dy[k] = dy;
    pkt_len[k] = len;
    pkt_base[k] = base;
    pkt_seen[k] = 1'b0;
  endtask

  task automatic build_table();
    set_packet(0, PORT_N, 4'd1, 4'd2, 3, 22'h00a10);   // To south.
    set_packet(1, PORT_E, 4'd1, 4'd1, 2, 22'h01b20);   // To local.
    set_packet(2, PORT_W, 4'd2, 4'd0, 4, 22'h02c30);
    set_packet(3, PORT_S, 4'd0, 4'd3, 1, 22'h03d40);
    set_packet(4, PORT_L, 4'd1, 4'd0, 3, 22'h04e50);
    set_packet(5, PORT_N, 4'd3, 4'd1, 2, 22'h05f60);
    set_packet(6, PORT_S, 4'd2, 4'd2, 3, 22'h06070);
    set_packet(7, PORT_L, 4'd1, 4'd1, 1, 22'h07180);
    set_packet(8, PORT_W, 4'd1, 4'd1, 4, 22'h08290);
    set_packet(9, PORT_E, 4'd0, 4'd1, 2, 22'h093a0);
    set_packet(10, PORT_N, 4'd1, 4'd0, 2, 22'h0a4b0);
    set_packet(11, PORT_S, 4'd1, 4'd3, 3, 22'h0b5c0);
    set_packet(12, PORT_E, 4'd1, 4'd3, 1, 22'h0c6d0);
  endtask

  // Packets from one source go out in table order.
  always @(posedge clk) begin
    for (int p = 0; p < NUM_PORTS; p++) begin
      if (rts_in[p] && dcts_out[p])
        src_pos[p] = src_pos[p] + 1;
      if (!rst && (src_pos[p] < src_len[p])) begin
        rts_in[p] <= 1'b1;
        flit_in_a[p] <= src_mem[p][src_pos[p]];
      end else begin
        rts_in[p] <= 1'b0;
      end
    end
  end

  // Sinks log transfers and watch that a stalled flit holds.
  always @(posedge clk) begin
    for (int o = 0; o < NUM_PORTS; o++) begin
      if (hold_pend[o]) begin
        assert (rts_out[o]) else begin
          $display("error rts_out[%0d] under back-pressure: expected %h, actual %h",
                   o, 1'b1, rts_out[o]);
          errors++;
        end
        assert (flit_out_a[o] == hold_flit[o]) else begin
          $display("error flit_out_%s under back-pressure: expected %h, actual %h",
                   port_name(o), hold_flit[o], flit_out_a[o]);
          errors++;
        end
      end
      hold_pend[o] = rts_out[o] && !dcts_in[o];
      hold_flit[o] = flit_out_a[o];
      if (rts_out[o] && dcts_in[o]) begin
        if (log_len[o] < max_log)
          log_mem[o][log_len[o]] = flit_out_a[o];
        log_len[o] = log_len[o] + 1;
      end
      if (rst)
        dcts_in[o] <= 1'b0;
      else
        dcts_in[o] <= (($urandom % 100) < 70);  // Ready about 70 percent of cycles.
    end
  end

  task automatic check_output_log(int o);
    int i;
    int k;
    i = 0;
    while (i < log_len[o] && i < max_log) begin
      k = find_head(log_mem[o][i]);
      assert (k >= 0) else begin
        $display("Flit %h at position %0d of output %s starts no known packet.",
                 log_mem[o][i], i, port_name(o));
        errors++;
      end
      if (k < 0) begin
        i = i + 1;
      end else begin
        assert (xy_route(pkt_dx[k], pkt_dy[k]) == o) else begin
          $display("error flit_out_%s route of packet %0d: expected %h, actual %h",
                   port_name(o), k, xy_route(pkt_dx[k], pkt_dy[k]), o);
          errors++;
        end
        assert (!pkt_seen[k]) else begin
          $display("Packet %0d arrived more than once.", k);
          errors++;
        end
        pkt_seen[k] = 1'b1;
        for (int j = 1; j < pkt_len[k]; j++) begin
          assert (i + j < log_len[o] && i + j < max_log) else begin
            $display("Packet %0d on output %s is cut short.", k, port_name(o));
            errors++;
          end
          if (i + j < log_len[o] && i + j < max_log) begin
            assert (log_mem[o][i + j] == expected_flit(k, j)) else begin
              $display("error flit_out_%s packet %0d flit %0d: expected %h, actual %h",
                       port_name(o), k, j, expected_flit(k, j), log_mem[o][i + j]);
              errors++;
            end
          end
        end
        i = i + pkt_len[k];
      end
    end
  endtask

  initial begin
    int cycles;
    int flit_total;
    int want;
    bit timed_out;
    void'($urandom(32'h23d6));
    clk = 1'b0;
    rst = 1'b1;
    rts_in = '0;
    dcts_in = '0;
    errors = 0;
    flit_total = 0;
    for (int p = 0; p < NUM_PORTS; p++) begin
      flit_in_a[p] = '0;
      src_len[p] = 0;
      src_pos[p] = 0;
      log_len[p] = 0;
      hold_pend[p] = 1'b0;
      hold_flit[p] = '0;
    end
    build_table();
    for (int k = 0; k < num_pkt; k++) begin
      for (int j = 0; j < pkt_len[k]; j++) begin
        src_mem[pkt_src[k]][src_len[pkt_src[k]]] = expected_flit(k, j);
        src_len[pkt_src[k]] = src_len[pkt_src[k]] + 1;
      end
      flit_total = flit_total + pkt_len[k];
    end

    repeat (16) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    assert (rts_out == 5'h00) else begin
      $display("error rts_out after reset: expected %h, actual %h", 5'h00, rts_out);
      errors++;
    end
    assert (dcts_out == 5'h1f) else begin
      $display("error dcts_out after reset: expected %h, actual %h", 5'h1f, dcts_out);
      errors++;
    end

    cycles = 0;
    while (logged_total() < flit_total && cycles < drain_limit) begin
      @(negedge clk);
      cycles++;
    end
    timed_out = (logged_total() < flit_total);
    assert (!timed_out) else begin
      $display("Drain wait timed out after %0d cycles.", drain_limit);
      errors++;
    end
    repeat (4) @(negedge clk);  // Room for any stray transfer to show up.

    if (!timed_out) begin
      assert (rts_out == 5'h00) else begin
        $display("error rts_out at end: expected %h, actual %h", 5'h00, rts_out);
        errors++;
      end
      assert (dcts_out == 5'h1f) else begin
        $display("error dcts_out at end: expected %h, actual %h", 5'h1f, dcts_out);
        errors++;
      end
    end

    for (int o = 0; o < NUM_PORTS; o++) begin
      want = 0;
      for (int k = 0; k < num_pkt; k++) begin
        if (xy_route(pkt_dx[k], pkt_dy[k]) == o)
          want = want + pkt_len[k];
      end
      assert (log_len[o] == want) else begin
        $display("error transfers on flit_out_%s: expected %h, actual %h",
                 port_name(o), want, log_len[o]);
        errors++;
      end
      check_output_log(o);
    end
    for (int k = 0; k < num_pkt; k++) begin
      assert (pkt_seen[k]) else begin
        $display("Packet %0d from input %s never arrived.", k, port_name(pkt_src[k]));
        errors++;
      end
    end

    $display("Run complete with %0d error(s).", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: design/router_top.sv
`timescale 1ns/1ps
`default_nettype none

module router_top import router_pkg::*; #(
  parameter int fifo_depth = 4,
  parameter coord_t local_x = 4'd0,
  parameter coord_t local_y = 4'd0
) (
  input  logic      clk,
  input  logic      rst,
  input  flit_t     flit_in_n,
  input  flit_t     flit_in_e,
  input  flit_t     flit_in_w,
  input  flit_t     flit_in_s,
  input  flit_t     flit_in_l,
  input  port_vec_t rts_in,
  input  port_vec_t dcts_in,
  output port_vec_t dcts_out,
  output flit_t     flit_out_n,
  output flit_t     flit_out_e,
  output flit_t     flit_out_w,
  output flit_t     flit_out_s,
  output flit_t     flit_out_l,
  output port_vec_t rts_out
);

  flit_t flit_in_a [NUM_PORTS];
  flit_t head_a [NUM_PORTS];
  flit_t flit_out_a [NUM_PORTS];
  port_vec_t req_in [NUM_PORTS];     // By input, one bit per output.
  port_vec_t grant_in [NUM_PORTS];
  port_vec_t req_out [NUM_PORTS];    // By output, one bit per input.
  port_vec_t grant_out [NUM_PORTS];

  assign flit_in_a[PORT_N] = flit_in_n;
  assign flit_in_a[PORT_E] = flit_in_e;
  assign flit_in_a[PORT_W] = flit_in_w;
  assign flit_in_a[PORT_S] = flit_in_s;
  assign flit_in_a[PORT_L] = flit_in_l;

  assign flit_out_n = flit_out_a[PORT_N];
  assign flit_out_e = flit_out_a[PORT_E];
  assign flit_out_w = flit_out_a[PORT_W];
  assign flit_out_s = flit_out_a[PORT_S];
  assign flit_out_l = flit_out_a[PORT_L];

  for (genvar p = 0; p < NUM_PORTS; p++) begin : g_in
    input_port #(
      .fifo_depth(fifo_depth),
      .local_x(local_x),
      .local_y(local_y)
    ) in_port (
      .clk(clk),
      .rst(rst),
      .flit_in(flit_in_a[p]),
      .rts_in(rts_in[p]),
      .grant(grant_in[p]),
      .dcts_out(dcts_out[p]),
      .head_flit(head_a[p]),
      .req(req_in[p])
    );

    for (genvar o = 0; o < NUM_PORTS; o++) begin : g_xpose
      assign req_out[o][p] = req_in[p][o];
      assign grant_in[p][o] = grant_out[o][p];
    end
  end

  for (genvar o = 0; o < NUM_PORTS; o++) begin : g_out
    output_port out_port (
      .clk(clk),
      .rst(rst),
      .req(req_out[o]),
      .dcts_in(dcts_in[o]),
      .head_n(head_a[PORT_N]),
      .head_e(head_a[PORT_E]),
      .head_w(head_a[PORT_W]),
      .head_s(head_a[PORT_S]),
      .head_l(head_a[PORT_L]),
      .grant(grant_out[o]),
      .flit_out(flit_out_a[o]),
      .rts_out(rts_out[o])
    );
  end

endmodule

`default_nettype wire

// File: design/output_port.sv
`timescale 1ns/1ps
`default_nettype none

module output_port import router_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  port_vec_t req,
  input  logic      dcts_in,
  input  flit_t     head_n,
  input  flit_t     head_e,
  input  flit_t     head_w,
  input  flit_t     head_s,
  input  flit_t     head_l,
  output port_vec_t grant,
  output flit_t     flit_out,
  output logic      rts_out
);

  port_vec_t xbar_sel;

  output_arbiter arb0 (
    .clk(clk),
    .rst(rst),
    .req(req),
    .dcts_in(dcts_in),
    .grant(grant),
    .xbar_sel(xbar_sel),
    .rts_out(rts_out)
  );

  // AND-OR select, an empty select gives zero on the link.
  assign flit_out = ({$bits(flit_t){xbar_sel[PORT_N]}} & head_n) |
                    ({$bits(flit_t){xbar_sel[PORT_E]}} & head_e) |
                    ({$bits(flit_t){xbar_sel[PORT_W]}} & head_w) |
                    ({$bits(flit_t){xbar_sel[PORT_S]}} & head_s) |
                    ({$bits(flit_t){xbar_sel[PORT_L]}} & head_l);

  a_sel_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(xbar_sel))
    else $error("output_port: crossbar select has more than one bit set.");

endmodule

`default_nettype wire

// File: design/output_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module output_arbiter import router_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  port_vec_t req,
  input  logic      dcts_in,
  output port_vec_t grant,
  output port_vec_t xbar_sel,
  output logic      rts_out
);

  arb_state_t state_q;
  arb_state_t state_d;
  arb_state_t next_state;
  logic xfer;

  function automatic arb_state_t port_state(int idx);
    case (idx)
      PORT_N: return ARB_N;
      PORT_E: return ARB_E;
      PORT_W: return ARB_W;
      PORT_S: return ARB_S;
      default: return ARB_L;
    endcase
  endfunction

  // First requester at or after start, wrapping in N, E, W, S, L order.
  function automatic arb_state_t pick(port_vec_t r, int start);
    int idx;
    arb_state_t found;
    found = ARB_IDLE;
    for (int k = NUM_PORTS - 1; k >= 0; k--) begin
      idx = (start + k) % NUM_PORTS;
      if (r[idx]) begin
        found = port_state(idx);
      end
    end
    return found;
  endfunction

  // Starting at the current input keeps a packet locked while it requests.
  always_comb begin
    case (state_q)
      ARB_N: next_state = pick(req, PORT_N);
      ARB_E: next_state = pick(req, PORT_E);
      ARB_W: next_state = pick(req, PORT_W);
      ARB_S: next_state = pick(req, PORT_S);
      default: next_state = pick(req, PORT_L);  // Idle and local both start at local.
    endcase
  end

  always_comb begin
    case (state_q)
      ARB_N: xbar_sel = 5'b00001;
      ARB_E: xbar_sel = 5'b00010;
      ARB_W: xbar_sel = 5'b00100;
      ARB_S: xbar_sel = 5'b01000;
      ARB_L: xbar_sel = 5'b10000;
      default: xbar_sel = 5'b00000;
    endcase
  end

  assign xfer = rts_out && dcts_in;
  assign grant = xbar_sel & {NUM_PORTS{xfer}};

  // A pending flit pins the state until the receiver takes it.
  assign state_d = (rts_out && !dcts_in) ? state_q : next_state;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ARB_IDLE;
      rts_out <= 1'b0;
    end else begin
      state_q <= state_d;
      rts_out <= (state_d != ARB_IDLE) && !xfer;
    end
  end

  a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
    else $error("output_arbiter: grant has more than one bit set.");

  a_hold: assert property (@(posedge clk) disable iff (rst)
    (rts_out && !dcts_in) |=> (rts_out && $stable(state_q)))
    else $error("output_arbiter: state or RTS moved under back-pressure.");

endmodule

`default_nettype wire

// File: design/input_port.sv
`timescale 1ns/1ps
`default_nettype none

module input_port import router_pkg::*; #(
  parameter int fifo_depth = 4,
  parameter coord_t local_x = 4'd0,
  parameter coord_t local_y = 4'd0
) (
  input  logic      clk,
  input  logic      rst,
  input  flit_t     flit_in,
  input  logic      rts_in,
  input  port_vec_t grant,
  output logic      dcts_out,
  output flit_t     head_flit,
  output port_vec_t req
);

  logic full;
  logic empty;
  logic starts_packet;
  logic ends_packet;
  coord_t dest_x;
  coord_t dest_y;
  port_vec_t route_q;
  port_vec_t route_calc;

  flit_fifo #(.fifo_depth(fifo_depth)) fifo0 (
    .clk(clk),
    .rst(rst),
    .wr_en(rts_in && dcts_out),
    .wr_flit(flit_in),
    .rd_en(|grant),          // Only one output can hold this input.
    .rd_flit(head_flit),
    .full(full),
    .empty(empty)
  );

  assign dcts_out = !full;

  assign dest_x = flit_dest_x(head_flit);
  assign dest_y = flit_dest_y(head_flit);
  assign starts_packet = (flit_kind(head_flit) == FLIT_HEAD) ||
                         (flit_kind(head_flit) == FLIT_SINGLE);
  assign ends_packet = (flit_kind(head_flit) == FLIT_TAIL) ||
                       (flit_kind(head_flit) == FLIT_SINGLE);

  // XY order, x is resolved first.
  always_comb begin
    route_calc = '0;
    if (dest_x > local_x) begin
      route_calc[PORT_E] = 1'b1;
    end else if (dest_x < local_x) begin
      route_calc[PORT_W] = 1'b1;
    end else if (dest_y > local_y) begin
      route_calc[PORT_S] = 1'b1;
    end else if (dest_y < local_y) begin
      route_calc[PORT_N] = 1'b1;
    end else begin
      route_calc[PORT_L] = 1'b1;
    end
  end

  always_comb begin
    if (empty) begin
      req = '0;
    end else if (route_q != '0) begin
      req = route_q;
    end else if (starts_packet) begin
      req = route_calc;  // Head cycle, route not yet held.
    end else begin
      req = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      route_q <= '0;
    end else if ((|grant) && ends_packet) begin
      route_q <= '0;
    end else if (!empty && (route_q == '0) && starts_packet) begin
      route_q <= route_calc;
    end
  end

  a_req_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(req))
    else $error("input_port: request has more than one bit set.");

  a_grant_req: assert property (@(posedge clk) disable iff (rst) (grant & ~req) == '0)
    else $error("input_port: grant without a matching request.");

endmodule

`default_nettype wire

// File: design/flit_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module flit_fifo import router_pkg::*; #(
  parameter int fifo_depth = 4
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  wr_en,
  input  flit_t wr_flit,
  input  logic  rd_en,
  output flit_t rd_flit,
  output logic  full,
  output logic  empty
);

  localparam int ptr_w = $clog2(fifo_depth);

  flit_t mem [fifo_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [ptr_w:0] count;

  assign rd_flit = mem[rd_ptr];  // Front flit, visible without a read.
  assign full = (count == fifo_depth[ptr_w:0]);
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_ptr] <= wr_flit;
    end
  end

  // Pointers wrap on their own since the depth is a power of two.
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge clk) disable iff (rst) wr_en |-> !full)
    else $error("flit_fifo: write while full.");

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) rd_en |-> !empty)
    else $error("flit_fifo: read while empty.");

endmodule

`default_nettype wire

// File: design/router_pkg.sv
`default_nettype none

package router_pkg;

  typedef logic [31:0] flit_t;
  typedef logic [1:0] flit_type_t;
  typedef logic [3:0] coord_t;
  typedef logic [4:0] port_vec_t;

  typedef enum logic [2:0] {
    ARB_IDLE,
    ARB_N,
    ARB_E,
    ARB_W,
    ARB_S,
    ARB_L
  } arb_state_t;

  localparam flit_type_t FLIT_BODY = 2'b00;
  localparam flit_type_t FLIT_HEAD = 2'b01;
  localparam flit_type_t FLIT_TAIL = 2'b10;
  localparam flit_type_t FLIT_SINGLE = 2'b11;  // Head and tail in one flit.

  localparam int PORT_N = 0;
  localparam int PORT_E = 1;
  localparam int PORT_W = 2;
  localparam int PORT_S = 3;
  localparam int PORT_L = 4;
  localparam int NUM_PORTS = 5;

  function automatic flit_type_t flit_kind(flit_t f);
    return f[31:30];
  endfunction

  function automatic coord_t flit_dest_x(flit_t f);
    return f[29:26];
  endfunction

  function automatic coord_t flit_dest_y(flit_t f);
    return f[25:22];
  endfunction

endpackage

`default_nettype wire
